/* logic/config_pkg.sv */
`default_nettype none

package config_pkg;

   typedef logic [7:0] tile_addr_t;

   // Per-tile configuration word, MSB first.
   typedef struct packed {
      logic [15:0] sb_sel;   // Eight 2-bit switch selects.
      logic [1:0]  clb_op;
      logic [1:0]  cb1_sel;
      logic [1:0]  cb0_sel;
   } tile_config_t;

   // Broadcast from the bus slave to every tile.
   typedef struct packed {
      logic         en;
      tile_addr_t   addr;
      tile_config_t data;
   } cfg_write_t;

   localparam tile_addr_t EDGE_ADDR = 8'hF0;   // Edge port readback.

endpackage

`default_nettype wire

/* logic/fabric_pkg.sv */
`default_nettype none

package fabric_pkg;

   typedef logic [1:0] track_pair_t;   // Bit 0 is the lower reference track.

   typedef struct packed {
      track_pair_t left;
      track_pair_t right;
      track_pair_t top;
      track_pair_t bottom;
   } tile_in_t;

   typedef struct packed {
      track_pair_t left;
      track_pair_t right;
      track_pair_t top;
      track_pair_t bottom;
   } tile_out_t;

   typedef enum logic [1:0] {
      SB_OFF      = 2'd0,
      SB_CLB      = 2'd1,
      SB_OPPOSITE = 2'd2,
      SB_TURN     = 2'd3   // Next side clockwise.
   } sb_src_e;

   typedef enum logic [1:0] {
      OP_AND  = 2'd0,
      OP_OR   = 2'd1,
      OP_XOR  = 2'd2,
      OP_NAND = 2'd3
   } clb_op_e;

   typedef struct packed {
      track_pair_t tile0_left;
      track_pair_t tile1_right;
      track_pair_t tile0_top;
      track_pair_t tile0_bottom;
      track_pair_t tile1_top;
      track_pair_t tile1_bottom;
   } fabric_in_t;

   typedef struct packed {
      track_pair_t tile0_left;
      track_pair_t tile1_right;
      track_pair_t tile0_top;
      track_pair_t tile0_bottom;
      track_pair_t tile1_top;
      track_pair_t tile1_bottom;
   } fabric_out_t;

   typedef struct packed {
      fabric_out_t toggled;    // Sticky change flags.
      fabric_out_t snapshot;
   } edge_read_t;

endpackage

`default_nettype wire

/* logic/cfg_wb_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module cfg_wb_slave (
   input  wire                         clk,
   input  wire                         reset,
   input  wire                         wb_cyc,
   input  wire                         wb_stb,
   input  wire                         wb_we,
   input  wire config_pkg::tile_addr_t wb_adr,
   input  wire [31:0]                  wb_dat_w,
   input  wire fabric_pkg::edge_read_t edge_data,
   output logic [31:0]                 wb_dat_r,
   output logic                        wb_ack,
   output config_pkg::cfg_write_t      cfg,
   output logic                        edge_rd
);
   import config_pkg::*;

   logic req;
   logic ack_cycle;

   assign req       = wb_cyc && wb_stb;
   assign ack_cycle = wb_ack && req;

   always_ff @(posedge clk) begin
      if (reset) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= req && !wb_ack;   // Single cycle ack one clock after request.
      end
   end

   always_comb begin
      cfg.en   = ack_cycle && wb_we;
      cfg.addr = wb_adr;
      cfg.data = wb_dat_w[$bits(tile_config_t)-1:0];
   end

   assign edge_rd  = ack_cycle && !wb_we && (wb_adr == EDGE_ADDR);
   assign wb_dat_r = edge_rd ? 32'(edge_data) : 32'd0;   // Other reads give zero.

   ack_not_back_to_back: assert property (@(posedge clk) disable iff (reset)
      wb_ack |=> !wb_ack);

   // Master must keep the cycle open until it sees ack.
   ack_within_cycle: assert property (@(posedge clk) disable iff (reset)
      wb_ack |-> wb_cyc);

endmodule

`default_nettype wire

/* logic/connect_box.sv */
`timescale 1ns/1ps
`default_nettype none

module connect_box (
   input  wire       clk,
   input  wire       reset,
   input  wire [3:0] tracks,   // Side tracks, reference numbering.
   input  wire       load,
   input  wire [1:0] sel,
   output logic      pin
);

   logic [1:0] sel_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         sel_q <= 2'd0;
      end else if (load) begin
         sel_q <= sel;
      end
   end

   assign pin = tracks[sel_q];   // Plain mux onto the pin.

endmodule

`default_nettype wire

/* logic/clb.sv */
`timescale 1ns/1ps
`default_nettype none

module clb (
   input  wire                      clk,
   input  wire                      reset,
   input  wire                      a,
   input  wire                      b,
   input  wire                      load,
   input  wire fabric_pkg::clb_op_e op,
   output logic                     y
);
   import fabric_pkg::*;

   clb_op_e op_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         op_q <= OP_AND;
      end else if (load) begin
         op_q <= op;
      end
   end

   always_comb begin
      case (op_q)
         OP_AND:  y = a & b;
         OP_OR:   y = a | b;
         OP_XOR:  y = a ^ b;
         OP_NAND: y = ~(a & b);
         default: y = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

/* logic/switch_box.sv */
`timescale 1ns/1ps
`default_nettype none

module switch_box (
   input  wire                       clk,
   input  wire                       reset,
   input  wire fabric_pkg::tile_in_t tracks_in,
   input  wire                       clb_out,
   input  wire                       load,
   input  wire [15:0]                sel,
   output fabric_pkg::tile_out_t     tracks_out
);
   import fabric_pkg::*;

   logic [15:0] sel_q;
   logic [7:0]  opp_v;    // Indexed in sel field order.
   logic [7:0]  turn_v;
   logic [7:0]  nxt;

   always_ff @(posedge clk) begin
      if (reset) begin
         sel_q <= 16'd0;
      end else if (load) begin
         sel_q <= sel;
      end
   end

   // Output order is left, top, right, bottom from bit 0.
   assign opp_v  = {tracks_in.top, tracks_in.left, tracks_in.bottom, tracks_in.right};
   assign turn_v = {tracks_in.left, tracks_in.bottom, tracks_in.right, tracks_in.top};

   always_comb begin
      for (int i = 0; i < 8; i++) begin
         case (sb_src_e'(sel_q[2*i +: 2]))
            SB_CLB:      nxt[i] = clb_out;
            SB_OPPOSITE: nxt[i] = opp_v[i];
            SB_TURN:     nxt[i] = turn_v[i];
            default:     nxt[i] = 1'b0;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         tracks_out <= '0;
      end else begin
         tracks_out.left   <= nxt[1:0];
         tracks_out.top    <= nxt[3:2];
         tracks_out.right  <= nxt[5:4];
         tracks_out.bottom <= nxt[7:6];
      end
   end

   // Select word comes straight from the bus write data.
   sel_known_on_load: assert property (@(posedge clk) disable iff (reset)
      load |-> !$isunknown(sel));

endmodule

`default_nettype wire

/* logic/pe_tile.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_tile #(
   parameter config_pkg::tile_addr_t TILE_ADDR = 8'h00
) (
   input  wire                         clk,
   input  wire                         reset,
   input  wire config_pkg::cfg_write_t cfg,
   input  wire fabric_pkg::tile_in_t   tin,
   output fabric_pkg::tile_out_t       tout
);
   import fabric_pkg::*;

   logic       load;
   logic [3:0] cb0_tracks;
   logic [3:0] cb1_tracks;
   logic       cb0_pin;
   logic       cb1_pin;
   logic       clb_y;

   assign load = cfg.en && (cfg.addr == TILE_ADDR);   // Only address compare.

   // Right side tracks 0 and 2 come in and 1 and 3 go out.
   assign cb0_tracks = {tout.right[1], tin.right[1], tout.right[0], tin.right[0]};
   // Bottom side tracks 0 and 2 go out and 1 and 3 come in.
   assign cb1_tracks = {tin.bottom[1], tout.bottom[1], tin.bottom[0], tout.bottom[0]};

   connect_box u_cb0 (
      .clk    (clk),
      .reset  (reset),
      .tracks (cb0_tracks),
      .load   (load),
      .sel    (cfg.data.cb0_sel),
      .pin    (cb0_pin)
   );

   connect_box u_cb1 (
      .clk    (clk),
      .reset  (reset),
      .tracks (cb1_tracks),
      .load   (load),
      .sel    (cfg.data.cb1_sel),
      .pin    (cb1_pin)
   );

   clb u_clb (
      .clk   (clk),
      .reset (reset),
      .a     (cb0_pin),
      .b     (cb1_pin),
      .load  (load),
      .op    (clb_op_e'(cfg.data.clb_op)),
      .y     (clb_y)
   );

   switch_box u_sb (
      .clk        (clk),
      .reset      (reset),
      .tracks_in  (tin),
      .clb_out    (clb_y),
      .load       (load),
      .sel        (cfg.data.sb_sel),
      .tracks_out (tout)
   );

endmodule

`default_nettype wire

/* logic/edge_port.sv */
`timescale 1ns/1ps
`default_nettype none

module edge_port (
   input  wire                          clk,
   input  wire                          reset,
   input  wire fabric_pkg::fabric_out_t fab_out,
   input  wire                          edge_rd,
   output fabric_pkg::fabric_out_t      boundary,
   output fabric_pkg::edge_read_t       edge_data
);
   import fabric_pkg::*;

   fabric_out_t toggled;
   fabric_out_t changed;

   assign changed = fab_out ^ boundary;   // Registered value about to change.

   always_ff @(posedge clk) begin
      if (reset) begin
         boundary <= '0;
         toggled  <= '0;
      end else begin
         boundary <= fab_out;
         // A change on the read edge survives the clear.
         toggled  <= (edge_rd ? '0 : toggled) | changed;
      end
   end

   always_comb begin
      edge_data.toggled  = toggled;
      edge_data.snapshot = boundary;
   end

endmodule

`default_nettype wire

/* logic/fabric_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fabric_top #(
   parameter config_pkg::tile_addr_t TILE0_ADDR = 8'h01,
   parameter config_pkg::tile_addr_t TILE1_ADDR = 8'h02
) (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          wb_cyc,
   input  wire                          wb_stb,
   input  wire                          wb_we,
   input  wire config_pkg::tile_addr_t  wb_adr,
   input  wire [31:0]                   wb_dat_w,
   input  wire fabric_pkg::fabric_in_t  fab_in,
   output logic [31:0]                  wb_dat_r,
   output logic                         wb_ack,
   output fabric_pkg::fabric_out_t      boundary
);
   import config_pkg::*;
   import fabric_pkg::*;

   cfg_write_t  cfg;
   edge_read_t  edge_data;
   logic        edge_rd;
   tile_in_t    t0_in;
   tile_in_t    t1_in;
   tile_out_t   t0_out;
   tile_out_t   t1_out;
   fabric_out_t fab_out;

   // Field order is left, right, top, bottom.
   assign t0_in = {fab_in.tile0_left, t1_out.left, fab_in.tile0_top, fab_in.tile0_bottom};
   assign t1_in = {t0_out.right, fab_in.tile1_right, fab_in.tile1_top, fab_in.tile1_bottom};

   assign fab_out = {t0_out.left, t1_out.right, t0_out.top, t0_out.bottom,
                     t1_out.top, t1_out.bottom};

   cfg_wb_slave u_slave (
      .clk       (clk),
      .reset     (reset),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_w  (wb_dat_w),
      .edge_data (edge_data),
      .wb_dat_r  (wb_dat_r),
      .wb_ack    (wb_ack),
      .cfg       (cfg),
      .edge_rd   (edge_rd)
   );

   pe_tile #(.TILE_ADDR(TILE0_ADDR)) u_tile0 (
      .clk   (clk),
      .reset (reset),
      .cfg   (cfg),
      .tin   (t0_in),
      .tout  (t0_out)
   );

   pe_tile #(.TILE_ADDR(TILE1_ADDR)) u_tile1 (
      .clk   (clk),
      .reset (reset),
      .cfg   (cfg),
      .tin   (t1_in),
      .tout  (t1_out)
   );

   edge_port u_edge (
      .clk       (clk),
      .reset     (reset),
      .fab_out   (fab_out),
      .edge_rd   (edge_rd),
      .boundary  (boundary),
      .edge_data (edge_data)
   );

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
   parameter int HALF_PERIOD_NS = 2   // 4 ns period.
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD_NS) clk = ~clk;
   end

endmodule

`default_nettype wire

/* verification/fabric_model.sv */
`timescale 1ns/1ps
`default_nettype none

module fabric_model #(
   parameter config_pkg::tile_addr_t TILE0_ADDR = 8'h01,
   parameter config_pkg::tile_addr_t TILE1_ADDR = 8'h02
) (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          wb_cyc,
   input  wire                          wb_stb,
   input  wire                          wb_we,
   input  wire config_pkg::tile_addr_t  wb_adr,
   input  wire [31:0]                   wb_dat_w,
   input  wire fabric_pkg::fabric_in_t  fab_in,
   output fabric_pkg::fabric_out_t      exp_boundary,
   output logic                         exp_ack,
   output logic [31:0]                  exp_rdata
);
   import config_pkg::*;
   import fabric_pkg::*;

   tile_config_t tile_cfg [2];
   tile_out_t    tile_q [2];
   fabric_out_t  snap_q;
   fabric_out_t  flag_q;
   logic         ack_q;

   // Sides numbered clockwise from the left.
   function automatic track_pair_t side_of(input tile_in_t t, input int s);
      case (s)
         0:       return t.left;
         1:       return t.top;
         2:       return t.right;
         default: return t.bottom;
      endcase
   endfunction

   function automatic tile_out_t tile_next(input tile_config_t c, input tile_in_t ti,
                                           input tile_out_t to);
      track_pair_t pairs [4];
      track_pair_t opp;
      track_pair_t turn;
      tile_out_t   r;
      logic        a;
      logic        b;
      logic        y;
      // Select bit 1 is the pair index, bit 0 picks incoming or outgoing.
      a = c.cb0_sel[0] ? to.right[c.cb0_sel[1]] : ti.right[c.cb0_sel[1]];
      b = c.cb1_sel[0] ? ti.bottom[c.cb1_sel[1]] : to.bottom[c.cb1_sel[1]];
      case (clb_op_e'(c.clb_op))
         OP_AND:  y = a & b;
         OP_OR:   y = a | b;
         OP_XOR:  y = a ^ b;
         OP_NAND: y = ~(a & b);
         default: y = 1'b0;
      endcase
      for (int s = 0; s < 4; s++) begin
         opp  = side_of(ti, (s + 2) % 4);
         turn = side_of(ti, (s + 1) % 4);   // Next side clockwise.
         for (int k = 0; k < 2; k++) begin
            case (sb_src_e'(c.sb_sel[4*s + 2*k +: 2]))
               SB_CLB:      pairs[s][k] = y;
               SB_OPPOSITE: pairs[s][k] = opp[k];
               SB_TURN:     pairs[s][k] = turn[k];
               default:     pairs[s][k] = 1'b0;
            endcase
         end
      end
      r.left   = pairs[0];
      r.top    = pairs[1];
      r.right  = pairs[2];
      r.bottom = pairs[3];
      return r;
   endfunction

   task automatic apply_edge();
      tile_in_t    t0_in;
      tile_in_t    t1_in;
      tile_out_t   t0_nxt;
      tile_out_t   t1_nxt;
      fabric_out_t outs;
      logic        ack_cycle;
      t0_in.left   = fab_in.tile0_left;
      t0_in.right  = tile_q[1].left;
      t0_in.top    = fab_in.tile0_top;
      t0_in.bottom = fab_in.tile0_bottom;
      t1_in.left   = tile_q[0].right;
      t1_in.right  = fab_in.tile1_right;
      t1_in.top    = fab_in.tile1_top;
      t1_in.bottom = fab_in.tile1_bottom;
      t0_nxt = tile_next(tile_cfg[0], t0_in, tile_q[0]);
      t1_nxt = tile_next(tile_cfg[1], t1_in, tile_q[1]);
      outs.tile0_left   = tile_q[0].left;
      outs.tile1_right  = tile_q[1].right;
      outs.tile0_top    = tile_q[0].top;
      outs.tile0_bottom = tile_q[0].bottom;
      outs.tile1_top    = tile_q[1].top;
      outs.tile1_bottom = tile_q[1].bottom;
      ack_cycle = ack_q && wb_cyc && wb_stb;
      if (ack_cycle && !wb_we && wb_adr == EDGE_ADDR) begin
         flag_q = '0;
      end
      flag_q = flag_q | (outs ^ snap_q);   // Change on the read edge stays set.
      snap_q = outs;
      if (ack_cycle && wb_we && wb_adr == TILE0_ADDR) begin
         tile_cfg[0] = wb_dat_w[$bits(tile_config_t)-1:0];
      end
      if (ack_cycle && wb_we && wb_adr == TILE1_ADDR) begin
         tile_cfg[1] = wb_dat_w[$bits(tile_config_t)-1:0];
      end
      tile_q[0] = t0_nxt;
      tile_q[1] = t1_nxt;
      ack_q = wb_cyc && wb_stb && !ack_q;
   endtask

   always @(posedge clk) begin
      if (reset) begin
         tile_cfg[0] = '0;
         tile_cfg[1] = '0;
         tile_q[0]   = '0;
         tile_q[1]   = '0;
         snap_q      = '0;
         flag_q      = '0;
         ack_q       = 1'b0;
      end else begin
         apply_edge();
      end
   end

   always_comb begin
      exp_boundary = snap_q;
      exp_ack      = ack_q;
      if (ack_q && wb_cyc && wb_stb && !wb_we && wb_adr == EDGE_ADDR) begin
         exp_rdata = {8'd0, flag_q, snap_q};
      end else begin
         exp_rdata = 32'd0;
      end
   end

endmodule

`default_nettype wire

/* verification/fabric_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fabric_tb;
   import config_pkg::*;
   import fabric_pkg::*;

   localparam tile_addr_t TILE0_ADDR = 8'h01;
   localparam tile_addr_t TILE1_ADDR = 8'h02;
   localparam int ROUNDS      = 20;
   localparam int RUN_CYCLES  = 120;
   localparam int CYCLE_LIMIT = 4000;   // 20 rounds of about 150 cycles plus margin.

   logic        clk;
   logic        reset;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   tile_addr_t  wb_adr;
   logic [31:0] wb_dat_w;
   logic [31:0] wb_dat_r;
   logic        wb_ack;
   fabric_in_t  fab_in;
   fabric_out_t boundary;
   fabric_out_t exp_boundary;
   logic        exp_ack;
   logic [31:0] exp_rdata;
   logic [31:0] rdata;
   logic        hold_tracks;
   integer      seed;
   int          cycle_count = 0;

   tb_clock #(.HALF_PERIOD_NS(2)) u_clock (.clk(clk));

   fabric_model #(
      .TILE0_ADDR (TILE0_ADDR),
      .TILE1_ADDR (TILE1_ADDR)
   ) u_model (
      .clk          (clk),
      .reset        (reset),
      .wb_cyc       (wb_cyc),
      .wb_stb       (wb_stb),
      .wb_we        (wb_we),
      .wb_adr       (wb_adr),
      .wb_dat_w     (wb_dat_w),
      .fab_in       (fab_in),
      .exp_boundary (exp_boundary),
      .exp_ack      (exp_ack),
      .exp_rdata    (exp_rdata)
   );

   fabric_top #(
      .TILE0_ADDR (TILE0_ADDR),
      .TILE1_ADDR (TILE1_ADDR)
   ) UUT (
      .clk      (clk),
      .reset    (reset),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .fab_in   (fab_in),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .boundary (boundary)
   );

   task automatic fail_now();
      $display("Test failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_boundary(input fabric_out_t got, input fabric_out_t exp,
                                 input string what);
      if (got !== exp) begin
         $display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, what, got, exp);
         fail_now();
      end
   endtask

   task automatic check_edge_read(input edge_read_t got, input edge_read_t exp,
                                  input string what);
      if (got !== exp) begin
         $display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, what, got, exp);
         fail_now();
      end
   endtask

   task automatic check_ack(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("CHECK FAILED at %0d ns: %s got %b expected %b", $time, what, got, exp);
         fail_now();
      end
   endtask

   function automatic logic [31:0] random_word();
      return $random(seed);
   endfunction

   function automatic tile_addr_t random_addr_except(input tile_addr_t a, input tile_addr_t b);
      logic [31:0] w;
      w = random_word();
      while (w[7:0] == a || w[7:0] == b) begin
         w = random_word();
      end
      return w[7:0];
   endfunction

   task automatic drive_tracks();
      logic [31:0] w;
      if (!hold_tracks) begin
         w = random_word();
         fab_in = w[11:0];
      end
   endtask

   task automatic run_cycles(input int n);
      repeat (n) begin
         @(negedge clk);
         drive_tracks();
      end
   endtask

   // Wishbone classic master holding the request until ack.
   task automatic wb_transfer(input logic we, input tile_addr_t adr, input logic [31:0] dat,
                              output logic [31:0] data_out);
      int         waited;
      edge_read_t got;
      edge_read_t exp;
      @(negedge clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = dat;
      drive_tracks();
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
         if (wb_ack !== 1'b1) begin
            drive_tracks();
         end
      end while (wb_ack !== 1'b1);
      if (waited != 1) begin
         $display("CHECK FAILED at %0d ns: ack came %0d cycles after the request, expected 1",
                  $time, waited);
         fail_now();
      end
      data_out = wb_dat_r;
      got = wb_dat_r[23:0];
      exp = exp_rdata[23:0];
      check_edge_read(got, exp, "read data");
      if (wb_dat_r[31:24] !== 8'd0) begin
         $display("CHECK FAILED at %0d ns: read data upper byte %h, expected 00",
                  $time, wb_dat_r[31:24]);
         fail_now();
      end
      drive_tracks();
      @(negedge clk);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      drive_tracks();
   endtask

   always @(negedge clk) begin
      if (!reset) begin
         check_boundary(boundary, exp_boundary, "boundary tracks");
         check_ack(wb_ack, exp_ack, "wb_ack");
      end
   end

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("ERROR: cycle limit of %0d reached before the tests finished", CYCLE_LIMIT);
         fail_now();
      end
   end

   initial begin
      edge_read_t got_edge;
      reset       = 1'b1;
      wb_cyc      = 1'b0;
      wb_stb      = 1'b0;
      wb_we       = 1'b0;
      wb_adr      = '0;
      wb_dat_w    = '0;
      fab_in      = '0;
      hold_tracks = 1'b1;
      seed        = 32'hbe9f;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      check_boundary(boundary, '0, "boundary after reset");
      wb_transfer(1'b0, EDGE_ADDR, 32'd0, rdata);
      got_edge = rdata[23:0];
      check_edge_read(got_edge, '0, "edge read after reset");

      hold_tracks = 1'b0;
      for (int round = 0; round < ROUNDS; round++) begin
         if (round % 3 != 2) begin
            wb_transfer(1'b1, TILE0_ADDR, random_word(), rdata);
         end
         if (round % 3 != 1) begin
            wb_transfer(1'b1, TILE1_ADDR, random_word(), rdata);
         end
         wb_transfer(1'b1, random_addr_except(TILE0_ADDR, TILE1_ADDR), random_word(), rdata);
         run_cycles(RUN_CYCLES);
         wb_transfer(1'b0, EDGE_ADDR, 32'd0, rdata);
         wb_transfer(1'b0, EDGE_ADDR, 32'd0, rdata);
         wb_transfer(1'b0, random_addr_except(EDGE_ADDR, EDGE_ADDR), 32'd0, rdata);
      end

      // All switches off and inputs still, so nothing toggles after the first read.
      hold_tracks = 1'b1;
      fab_in      = '0;
      wb_transfer(1'b1, TILE0_ADDR, 32'd0, rdata);
      wb_transfer(1'b1, TILE1_ADDR, 32'd0, rdata);
      run_cycles(4);
      wb_transfer(1'b0, EDGE_ADDR, 32'd0, rdata);
      wb_transfer(1'b0, EDGE_ADDR, 32'd0, rdata);
      got_edge = rdata[23:0];
      check_edge_read(got_edge, '0, "second edge read of a quiet fabric");

      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
logic/config_pkg.sv
logic/fabric_pkg.sv
logic/cfg_wb_slave.sv
logic/connect_box.sv
logic/clb.sv
logic/switch_box.sv
logic/pe_tile.sv
logic/edge_port.sv
logic/fabric_top.sv
verification/tb_clock.sv
verification/fabric_model.sv
verification/fabric_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module fabric_tb \
   -f all.f -o fabric_sim &&
./obj_dir/fabric_sim || exit 1
